/* source/rv32im_pkg.sv */
package rv32im_pkg;

  localparam int XLEN     = 32;
  localparam int REG_BITS = 5;

  // Major opcodes, instruction bits 6:2
  localparam logic [4:0] OP_L     = 5'b00000;
  localparam logic [4:0] OP_AI    = 5'b00100;
  localparam logic [4:0] OP_AUIPC = 5'b00101;
  localparam logic [4:0] OP_S     = 5'b01000;
  localparam logic [4:0] OP_A     = 5'b01100;
  localparam logic [4:0] OP_LUI   = 5'b01101;
  localparam logic [4:0] OP_B     = 5'b11000;
  localparam logic [4:0] OP_JALR  = 5'b11001;
  localparam logic [4:0] OP_JAL   = 5'b11011;
  localparam logic [4:0] OP_SYS   = 5'b11100;

  localparam logic [REG_BITS-1:0] LINK_REG     = 5'd1;  // ra
  localparam logic [REG_BITS-1:0] LINK_REG_ALT = 5'd5;  // t0

  // Stage-4 path select, one-hot
  localparam logic [2:0] STAGE4_ALU = 3'b001;
  localparam logic [2:0] STAGE4_MEM = 3'b010;
  localparam logic [2:0] STAGE4_MUL = 3'b100;

  typedef struct packed {
    logic [6:0]          funct7;
    logic [REG_BITS-1:0] rs2;
    logic [REG_BITS-1:0] rs1;
    logic [2:0]          funct3;
    logic [REG_BITS-1:0] rd;
    logic [6:0]          opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]         imm;
    logic [REG_BITS-1:0] rs1;
    logic [2:0]          funct3;
    logic [REG_BITS-1:0] rd;
    logic [6:0]          opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]          imm_hi;
    logic [REG_BITS-1:0] rs2;
    logic [REG_BITS-1:0] rs1;
    logic [2:0]          funct3;
    logic [4:0]          imm_lo;
    logic [6:0]          opcode;
  } s_fmt_t;

  // Branch offset bits are scattered over the word
  typedef struct packed {
    logic                imm_12;
    logic [5:0]          imm_10_5;
    logic [REG_BITS-1:0] rs2;
    logic [REG_BITS-1:0] rs1;
    logic [2:0]          funct3;
    logic [3:0]          imm_4_1;
    logic                imm_11;
    logic [6:0]          opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]         imm;
    logic [REG_BITS-1:0] rd;
    logic [6:0]          opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                imm_20;
    logic [9:0]          imm_10_1;
    logic                imm_11;
    logic [7:0]          imm_19_12;
    logic [REG_BITS-1:0] rd;
    logic [6:0]          opcode;
  } j_fmt_t;

  // One fetched word, read through the format its opcode implies
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

endpackage

/* source/rv32im_imm_gen.sv */
`timescale 1ns/1ps

module rv32im_imm_gen (
  input  rv32im_pkg::instr_u              instr_i,
  input  logic [rv32im_pkg::XLEN-1:0]     pc_i,
  output logic [rv32im_pkg::XLEN-1:0]     imm_o,
  output logic [rv32im_pkg::XLEN-1:0]     upper_imm_o,
  output logic [rv32im_pkg::XLEN-1:0]     jal_target_o,
  output logic [rv32im_pkg::XLEN-1:0]     link_addr_o
);

  logic [4:0]                  op;
  logic [rv32im_pkg::XLEN-1:0] u_imm;
  logic [rv32im_pkg::XLEN-1:0] j_imm;

  assign op    = instr_i.r.opcode[6:2];
  assign u_imm = {instr_i.u.imm, 12'b0};
  assign j_imm = {{12{instr_i.j.imm_20}}, instr_i.j.imm_19_12, instr_i.j.imm_11,
                  instr_i.j.imm_10_1, 1'b0};

  always_comb
  begin
    case (op)
      rv32im_pkg::OP_S:
        imm_o = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
      rv32im_pkg::OP_B:
        imm_o = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                 instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
      default:  // I forms, funct3 bit 2 selects zero extension
        imm_o = instr_i.i.funct3[2] ? {20'b0, instr_i.i.imm}
                                    : {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
    endcase
  end

  assign upper_imm_o  = (op == rv32im_pkg::OP_AUIPC) ? u_imm + pc_i : u_imm;
  assign jal_target_o = pc_i + j_imm;
  assign link_addr_o  = pc_i + 32'd4;  // Return address

endmodule

/* source/rv32im_decode.sv */
`timescale 1ns/1ps

module rv32im_decode (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                clear_i,
  input  logic                                data_ready_i,
  input  rv32im_pkg::instr_u                  instruction_i,
  input  logic [rv32im_pkg::XLEN-1:0]         pc_data_i,
  input  logic [rv32im_pkg::XLEN-1:0]         imm_i,
  input  logic [rv32im_pkg::XLEN-1:0]         upper_imm_i,
  input  logic [rv32im_pkg::XLEN-1:0]         jal_target_i,
  input  logic [rv32im_pkg::XLEN-1:0]         link_addr_i,
  output logic                                issue_o,
  output logic [3:0]                          alu_operation_o,
  output logic [2:0]                          word_size_o,
  output logic [rv32im_pkg::REG_BITS-1:0]     rs1_addr_o,
  output logic [rv32im_pkg::REG_BITS-1:0]     rs2_addr_o,
  output logic [rv32im_pkg::REG_BITS-1:0]     rd_addr_o,
  output logic [rv32im_pkg::XLEN-1:0]         immediate_o,
  output logic                                immediate_valid_o,
  output logic [rv32im_pkg::XLEN-1:0]         pc_data_o,
  output logic                                jal_jump_o,
  output logic [rv32im_pkg::XLEN-1:0]         pc_jal_data_o,
  output logic                                jalr_o,
  output logic                                branch_o,
  output logic [2:0]                          branch_condition_o,
  output logic                                link_o,
  output logic [rv32im_pkg::XLEN-1:0]         link_data_o,
  output logic                                push_ras_o,
  output logic                                pop_ras_o,
  output logic [2:0]                          stage4_path_o,
  output logic                                memory_write_o,
  output logic                                mret_o
);

  // Instruction formats, one-hot
  localparam logic [5:0] R_TYPE = 6'b000001;
  localparam logic [5:0] I_TYPE = 6'b000010;
  localparam logic [5:0] S_TYPE = 6'b000100;
  localparam logic [5:0] U_TYPE = 6'b001000;
  localparam logic [5:0] B_TYPE = 6'b010000;
  localparam logic [5:0] J_TYPE = 6'b100000;

  logic [4:0] op;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [5:0] fmt;
  logic       take;
  logic       rd_link;
  logic       rs1_link;
  logic       push_ras;
  logic       pop_ras;

  assign op     = instruction_i.r.opcode[6:2];
  assign funct3 = instruction_i.r.funct3;
  assign funct7 = instruction_i.r.funct7;
  assign take   = data_ready_i & ~clear_i;  // Flush drops a wrong-path word

  always_comb
  begin
    case (op)
      rv32im_pkg::OP_A:                          fmt = R_TYPE;
      rv32im_pkg::OP_L, rv32im_pkg::OP_AI,
      rv32im_pkg::OP_JALR, rv32im_pkg::OP_SYS:   fmt = I_TYPE;
      rv32im_pkg::OP_S:                          fmt = S_TYPE;
      rv32im_pkg::OP_LUI, rv32im_pkg::OP_AUIPC:  fmt = U_TYPE;
      rv32im_pkg::OP_B:                          fmt = B_TYPE;
      rv32im_pkg::OP_JAL:                        fmt = J_TYPE;
      default:                                   fmt = 6'b0;
    endcase
  end

  // Return stack hints from the link register convention
  assign rd_link  = (instruction_i.r.rd == rv32im_pkg::LINK_REG) |
                    (instruction_i.r.rd == rv32im_pkg::LINK_REG_ALT);
  assign rs1_link = (instruction_i.r.rs1 == rv32im_pkg::LINK_REG) |
                    (instruction_i.r.rs1 == rv32im_pkg::LINK_REG_ALT);
  assign push_ras = rd_link & (op == rv32im_pkg::OP_JAL | op == rv32im_pkg::OP_JALR);
  assign pop_ras  = rs1_link & (op == rv32im_pkg::OP_JALR) &
                    (~push_ras | (instruction_i.r.rd == instruction_i.r.rs1));

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      issue_o           <= 1'b0;
      immediate_valid_o <= 1'b0;
      jal_jump_o        <= 1'b0;
      jalr_o            <= 1'b0;
      branch_o          <= 1'b0;
      link_o            <= 1'b0;
      memory_write_o    <= 1'b0;
      mret_o            <= 1'b0;
      push_ras_o        <= 1'b0;
      pop_ras_o         <= 1'b0;
    end
    else if (clear_i | data_ready_i)
    begin
      issue_o           <= take;
      immediate_valid_o <= take & ~(fmt == R_TYPE | fmt == B_TYPE);
      jal_jump_o        <= take & (op == rv32im_pkg::OP_JAL);
      jalr_o            <= take & (op == rv32im_pkg::OP_JALR);
      branch_o          <= take & (fmt == B_TYPE);
      link_o            <= take & (op == rv32im_pkg::OP_JAL | op == rv32im_pkg::OP_JALR);
      memory_write_o    <= take & (op == rv32im_pkg::OP_S);
      mret_o            <= take & (op == rv32im_pkg::OP_SYS);
      push_ras_o        <= take & push_ras;
      pop_ras_o         <= take & pop_ras;
    end
    else
      issue_o <= 1'b0;  // Flags hold as levels
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      pc_data_o          <= pc_data_i;
      pc_jal_data_o      <= jal_target_i;
      link_data_o        <= link_addr_i;
      immediate_o        <= (fmt == U_TYPE) ? upper_imm_i : imm_i;
      branch_condition_o <= (fmt == B_TYPE) ? funct3 : 3'b0;

      if (op == rv32im_pkg::OP_S || op == rv32im_pkg::OP_L)
        stage4_path_o <= rv32im_pkg::STAGE4_MEM;
      else if (op == rv32im_pkg::OP_A && funct7[0])
        stage4_path_o <= rv32im_pkg::STAGE4_MUL;  // M extension
      else
        stage4_path_o <= rv32im_pkg::STAGE4_ALU;

      // Unused register fields read as x0
      rs1_addr_o      <= '0;
      rs2_addr_o      <= '0;
      rd_addr_o       <= '0;
      alu_operation_o <= 4'b0;
      word_size_o     <= 3'b0;
      case (fmt)
        R_TYPE:
        begin
          rs1_addr_o      <= instruction_i.r.rs1;
          rs2_addr_o      <= instruction_i.r.rs2;
          rd_addr_o       <= instruction_i.r.rd;
          alu_operation_o <= {funct7[5], funct3};
        end
        I_TYPE:
        begin
          rs1_addr_o  <= instruction_i.i.rs1;
          rd_addr_o   <= instruction_i.i.rd;
          word_size_o <= funct3;
          if (!instruction_i.i.opcode[5])
            alu_operation_o <= {1'b0, funct3};  // Loads and immediate ALU only
        end
        S_TYPE, B_TYPE:
        begin
          rs1_addr_o  <= instruction_i.s.rs1;
          rs2_addr_o  <= instruction_i.s.rs2;
          word_size_o <= (fmt == S_TYPE) ? funct3 : 3'b0;
        end
        U_TYPE, J_TYPE:
          rd_addr_o <= instruction_i.u.rd;
        default:
          rd_addr_o <= '0;
      endcase
    end
  end

endmodule

/* source/rv32im_ras.sv */
`timescale 1ns/1ps

module rv32im_ras #(
  parameter int RAS_DEPTH = 4
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            push_i,
  input  logic                            pop_i,
  input  logic [rv32im_pkg::XLEN-1:0]     data_i,
  output logic [rv32im_pkg::XLEN-1:0]     ras_top_o
);

  localparam int PTR_BITS = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;

  logic [rv32im_pkg::XLEN-1:0] entry [RAS_DEPTH];
  logic [PTR_BITS-1:0]         ptr;       // Top entry
  logic [PTR_BITS-1:0]         ptr_up;
  logic [PTR_BITS-1:0]         ptr_down;

  // Wrap in both directions, oldest entry is overwritten on overflow
  assign ptr_up   = (ptr == PTR_BITS'(RAS_DEPTH - 1)) ? '0 : ptr + 1'b1;
  assign ptr_down = (ptr == '0) ? PTR_BITS'(RAS_DEPTH - 1) : ptr - 1'b1;

  assign ras_top_o = entry[ptr];

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ptr <= '0;
    else if (push_i && !pop_i)
      ptr <= ptr_up;
    else if (pop_i && !push_i)
      ptr <= ptr_down;
  end

  always_ff @(posedge clk_i)
  begin
    if (push_i && pop_i)
      entry[ptr] <= data_i;  // Replace top
    else if (push_i)
      entry[ptr_up] <= data_i;
  end

endmodule

/* source/rv32im_fetch.sv */
`timescale 1ns/1ps

module rv32im_fetch (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            instr_valid_i,
  input  logic                            irq_i,
  input  logic                            issue_i,
  input  logic                            jal_jump_i,
  input  logic [rv32im_pkg::XLEN-1:0]     jal_target_i,
  input  logic                            jalr_i,
  input  logic                            pop_i,
  input  logic [rv32im_pkg::XLEN-1:0]     ras_top_i,
  output logic [rv32im_pkg::XLEN-1:0]     pc_o,
  output logic                            flush_o,
  output logic [rv32im_pkg::XLEN-1:0]     uepc_o
);

  logic                        redirect;
  logic [rv32im_pkg::XLEN-1:0] target;

  // Only JAL and predicted returns leave straight-line code
  assign redirect = issue_i & (jal_jump_i | (jalr_i & pop_i));
  assign target   = jal_jump_i ? jal_target_i : ras_top_i;
  assign flush_o  = redirect;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      pc_o <= '0;
    else if (redirect)
      pc_o <= target;
    else if (instr_valid_i)
      pc_o <= pc_o + 32'd4;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      uepc_o <= '0;
    else if (irq_i)
      uepc_o <= pc_o;  // Trap PC
  end

endmodule

/* source/rv32im_front.sv */
`timescale 1ns/1ps

module rv32im_front #(
  parameter int RAS_DEPTH = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [rv32im_pkg::XLEN-1:0]         instr_i,
  input  logic                                instr_valid_i,
  input  logic                                irq_i,
  output logic [rv32im_pkg::XLEN-1:0]         pc_o,
  output logic [rv32im_pkg::XLEN-1:0]         uepc_o,
  output logic                                issue_o,
  output logic [3:0]                          alu_operation_o,
  output logic [2:0]                          word_size_o,
  output logic [rv32im_pkg::REG_BITS-1:0]     rs1_addr_o,
  output logic [rv32im_pkg::REG_BITS-1:0]     rs2_addr_o,
  output logic [rv32im_pkg::REG_BITS-1:0]     rd_addr_o,
  output logic [rv32im_pkg::XLEN-1:0]         immediate_o,
  output logic                                immediate_valid_o,
  output logic [rv32im_pkg::XLEN-1:0]         pc_data_o,
  output logic                                jal_jump_o,
  output logic [rv32im_pkg::XLEN-1:0]         pc_jal_data_o,
  output logic                                jalr_o,
  output logic                                branch_o,
  output logic [2:0]                          branch_condition_o,
  output logic                                link_o,
  output logic [rv32im_pkg::XLEN-1:0]         link_data_o,
  output logic                                push_ras_o,
  output logic                                pop_ras_o,
  output logic [2:0]                          stage4_path_o,
  output logic                                memory_write_o,
  output logic                                mret_o
);

  logic                        flush;
  logic                        ras_push;
  logic                        ras_pop;
  logic [rv32im_pkg::XLEN-1:0] imm;
  logic [rv32im_pkg::XLEN-1:0] upper_imm;
  logic [rv32im_pkg::XLEN-1:0] jal_target;
  logic [rv32im_pkg::XLEN-1:0] link_addr;
  logic [rv32im_pkg::XLEN-1:0] ras_top;

  // Stack flags are levels, act once per issued instruction
  assign ras_push = issue_o & push_ras_o;
  assign ras_pop  = issue_o & pop_ras_o;

  rv32im_fetch fetch0 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .irq_i         (irq_i),
    .issue_i       (issue_o),
    .jal_jump_i    (jal_jump_o),
    .jal_target_i  (pc_jal_data_o),
    .jalr_i        (jalr_o),
    .pop_i         (pop_ras_o),
    .ras_top_i     (ras_top),
    .pc_o          (pc_o),
    .flush_o       (flush),
    .uepc_o        (uepc_o)
  );

  rv32im_imm_gen imm_gen0 (
    .instr_i      (instr_i),
    .pc_i         (pc_o),
    .imm_o        (imm),
    .upper_imm_o  (upper_imm),
    .jal_target_o (jal_target),
    .link_addr_o  (link_addr)
  );

  rv32im_decode decode0 (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .clear_i            (flush),
    .data_ready_i       (instr_valid_i),
    .instruction_i      (instr_i),
    .pc_data_i          (pc_o),
    .imm_i              (imm),
    .upper_imm_i        (upper_imm),
    .jal_target_i       (jal_target),
    .link_addr_i        (link_addr),
    .issue_o            (issue_o),
    .alu_operation_o    (alu_operation_o),
    .word_size_o        (word_size_o),
    .rs1_addr_o         (rs1_addr_o),
    .rs2_addr_o         (rs2_addr_o),
    .rd_addr_o          (rd_addr_o),
    .immediate_o        (immediate_o),
    .immediate_valid_o  (immediate_valid_o),
    .pc_data_o          (pc_data_o),
    .jal_jump_o         (jal_jump_o),
    .pc_jal_data_o      (pc_jal_data_o),
    .jalr_o             (jalr_o),
    .branch_o           (branch_o),
    .branch_condition_o (branch_condition_o),
    .link_o             (link_o),
    .link_data_o        (link_data_o),
    .push_ras_o         (push_ras_o),
    .pop_ras_o          (pop_ras_o),
    .stage4_path_o      (stage4_path_o),
    .memory_write_o     (memory_write_o),
    .mret_o             (mret_o)
  );

  rv32im_ras #(
    .RAS_DEPTH (RAS_DEPTH)
  ) ras0 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .push_i    (ras_push),
    .pop_i     (ras_pop),
    .data_i    (link_data_o),
    .ras_top_o (ras_top)
  );

endmodule

/* include/tb_decode_ref.svh */
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

// Expected immediate_o of a word fetched at pc
function automatic logic [rv32im_pkg::XLEN-1:0] ref_imm(
  input rv32im_pkg::instr_u          w,
  input logic [rv32im_pkg::XLEN-1:0] pc
);
  logic [rv32im_pkg::XLEN-1:0] u;
  u = {w.u.imm, 12'b0};
  case (w.r.opcode[6:2])
    rv32im_pkg::OP_S:     return {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
    rv32im_pkg::OP_B:     return {{19{w.b.imm_12}}, w.b.imm_12, w.b.imm_11,
                                  w.b.imm_10_5, w.b.imm_4_1, 1'b0};
    rv32im_pkg::OP_LUI:   return u;
    rv32im_pkg::OP_AUIPC: return u + pc;
    default:              return w.i.funct3[2] ? {20'b0, w.i.imm}
                                               : {{20{w.i.imm[11]}}, w.i.imm};
  endcase
endfunction

// Packed as rs1, rs2, rd with unused fields zero
function automatic logic [3*rv32im_pkg::REG_BITS-1:0] ref_regs(input rv32im_pkg::instr_u w);
  case (w.r.opcode[6:2])
    rv32im_pkg::OP_A:                       return {w.r.rs1, w.r.rs2, w.r.rd};
    rv32im_pkg::OP_L, rv32im_pkg::OP_AI,
    rv32im_pkg::OP_JALR, rv32im_pkg::OP_SYS: return {w.r.rs1, 5'd0, w.r.rd};
    rv32im_pkg::OP_S, rv32im_pkg::OP_B:     return {w.r.rs1, w.r.rs2, 5'd0};
    rv32im_pkg::OP_LUI, rv32im_pkg::OP_AUIPC,
    rv32im_pkg::OP_JAL:                     return {10'd0, w.r.rd};
    default:                                return '0;
  endcase
endfunction

function automatic logic [3:0] ref_alu_op(input rv32im_pkg::instr_u w);
  case (w.r.opcode[6:2])
    rv32im_pkg::OP_A:                   return {w.r.funct7[5], w.r.funct3};
    rv32im_pkg::OP_L, rv32im_pkg::OP_AI: return {1'b0, w.r.funct3};
    default:                            return 4'b0;
  endcase
endfunction

function automatic logic [2:0] ref_stage4(input rv32im_pkg::instr_u w);
  if (w.r.opcode[6:2] == rv32im_pkg::OP_L || w.r.opcode[6:2] == rv32im_pkg::OP_S)
    return rv32im_pkg::STAGE4_MEM;
  if (w.r.opcode[6:2] == rv32im_pkg::OP_A && w.r.funct7[0])
    return rv32im_pkg::STAGE4_MUL;
  return rv32im_pkg::STAGE4_ALU;
endfunction

function automatic logic ref_imm_valid(input rv32im_pkg::instr_u w);
  return !(w.r.opcode[6:2] == rv32im_pkg::OP_A || w.r.opcode[6:2] == rv32im_pkg::OP_B);
endfunction

// PC after the issue of w, given the stack top at that time
function automatic logic [rv32im_pkg::XLEN-1:0] ref_next_pc(
  input rv32im_pkg::instr_u          w,
  input logic [rv32im_pkg::XLEN-1:0] pc,
  input logic [rv32im_pkg::XLEN-1:0] ras_top
);
  logic rd_link;
  logic rs1_link;
  rd_link  = (w.r.rd == rv32im_pkg::LINK_REG) || (w.r.rd == rv32im_pkg::LINK_REG_ALT);
  rs1_link = (w.r.rs1 == rv32im_pkg::LINK_REG) || (w.r.rs1 == rv32im_pkg::LINK_REG_ALT);
  if (w.r.opcode[6:2] == rv32im_pkg::OP_JAL)
    return pc + {{12{w.j.imm_20}}, w.j.imm_19_12, w.j.imm_11, w.j.imm_10_1, 1'b0};
  if (w.r.opcode[6:2] == rv32im_pkg::OP_JALR && rs1_link && (!rd_link || w.r.rd == w.r.rs1))
    return ras_top;
  return pc + 32'd4;
endfunction

`endif

/* testbench/tb_rv32im_front.sv */
`timescale 1ns/1ps

module tb_rv32im_front;

  localparam int XLEN = rv32im_pkg::XLEN;
  localparam int RB   = rv32im_pkg::REG_BITS;

  `include "tb_decode_ref.svh"

  logic            clk_i;
  logic            rst_n_i;
  logic [XLEN-1:0] instr_i;
  logic            instr_valid_i;
  logic            irq_i;
  logic [XLEN-1:0] pc_o, uepc_o, immediate_o, pc_data_o, pc_jal_data_o, link_data_o;
  logic [RB-1:0]   rs1_addr_o, rs2_addr_o, rd_addr_o;
  logic [3:0]      alu_operation_o;
  logic [2:0]      word_size_o, branch_condition_o, stage4_path_o;
  logic            issue_o, immediate_valid_o, jal_jump_o, jalr_o, branch_o, link_o;
  logic            push_ras_o, pop_ras_o, memory_write_o, mret_o;

  logic [XLEN-1:0]    imem [logic [XLEN-1:0]];  // Instruction memory by byte address
  rv32im_pkg::instr_u word_q [$];
  logic [XLEN-1:0]    pc_q [$];
  logic [XLEN-1:0]    ras_q [$];                // Expected return stack with the top at the back
  logic [XLEN-1:0]    exp_next_pc = '0;
  logic               pc_pending = 1'b0;
  int                 done_cnt = 0;
  int                 err_cnt = 0;
  int                 pass_cnt = 0;
  int                 fail_cnt = 0;
  int                 seed;
  string              test_name = "none";

  rv32im_front #(.RAS_DEPTH(4)) dut0 (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [XLEN-1:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [XLEN-1:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [XLEN-1:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [XLEN-1:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [XLEN-1:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [XLEN-1:0] read_mem(input logic [XLEN-1:0] addr);
    logic [24:0] fill;
    fill = addr[31:7] ^ addr[24:0];
    return imem.exists(addr) ? imem[addr] : {fill, 7'b0010011};  // Immediate ALU filler
  endfunction

  task automatic load_program();
    logic [XLEN-1:0] r;
    for (int k = 0; k < 4; k++)
    begin
      r = $random(seed);
      imem[4 * k] = {r[31:7], 7'b0110011};  // Random register ALU
    end
    imem[32'h10] = enc_r(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3);  // mul
    for (int k = 0; k < 2; k++)
    begin
      r = $random(seed);
      imem[32'h14 + 4 * k] = {r[31:7], 7'b0010011};
    end
    imem[32'h1c] = enc_i(12'hffc, 5'd2, 3'b010, 5'd5, 7'b0000011);  // lw
    imem[32'h20] = enc_i(12'h008, 5'd1, 3'b100, 5'd6, 7'b0000011);  // lbu
    imem[32'h24] = enc_s(12'd12, 5'd7, 5'd2, 3'b010);
    imem[32'h28] = {20'h12345, 5'd8, 7'b0110111};  // lui
    imem[32'h2c] = {20'hfffff, 5'd9, 7'b0010111};  // auipc
    imem[32'h30] = enc_b(13'd16, 5'd2, 5'd1, 3'b000);
    imem[32'h34] = enc_b(13'h1ff8, 5'd4, 5'd3, 3'b110);
    imem[32'h38] = enc_j(21'h48, 5'd0);  // Jump to 0x80
    imem[32'h3c] = {20'habcde, 5'd31, 7'b0110111};  // Wrong-path word that never issues
    imem[32'h80] = enc_i(12'd5, 5'd0, 3'b000, 5'd11, 7'b0010011);
    // Four nested calls then four returns
    for (int k = 0; k < 4; k++)
    begin
      imem[32'h84 + 32'h100 * k] = enc_j(21'h100, 5'd1);
      imem[32'h188 + 32'h100 * k] = enc_i(12'd0, 5'd1, 3'b000, 5'd0, 7'b1100111);
    end
    imem[32'h88] = enc_i(12'd7, 5'd0, 3'b000, 5'd12, 7'b0010011);
  endtask

  task automatic check_word(input string field, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp)
    begin
      $display("error %s: %s expected %h actual %h", test_name, field, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_reg(input string field, input logic [RB-1:0] exp,
                           input logic [RB-1:0] act);
    if (act !== exp)
    begin
      $display("error %s: %s expected %0d actual %0d", test_name, field, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_code(input string field, input logic [2:0] exp, input logic [2:0] act);
    if (act !== exp)
    begin
      $display("error %s: %s expected %b actual %b", test_name, field, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_alu(input string field, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp)
    begin
      $display("error %s: %s expected %h actual %h", test_name, field, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string field, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("error %s: %s expected %b actual %b", test_name, field, exp, act);
      err_cnt++;
    end
  endtask

  // Decode fields of one issued word plus the next PC and stack update
  task automatic compare_issue(input rv32im_pkg::instr_u w, input logic [XLEN-1:0] pc);
    logic [3*RB-1:0] regs;
    logic [4:0]      op;
    logic            jal;
    logic            jalr;
    logic            push;
    logic            pop;
    logic            sized;
    logic [XLEN-1:0] top;
    op    = w.r.opcode[6:2];
    regs  = ref_regs(w);
    jal   = (op == rv32im_pkg::OP_JAL);
    jalr  = (op == rv32im_pkg::OP_JALR);
    push  = (w.r.rd == 5'd1 || w.r.rd == 5'd5) && (jal || jalr);
    pop   = (w.r.rs1 == 5'd1 || w.r.rs1 == 5'd5) && jalr && (!push || w.r.rd == w.r.rs1);
    sized = op inside {rv32im_pkg::OP_L, rv32im_pkg::OP_AI, rv32im_pkg::OP_JALR,
                       rv32im_pkg::OP_SYS, rv32im_pkg::OP_S};
    top   = (ras_q.size() != 0) ? ras_q[$] : '0;
    check_word("pc_data", pc, pc_data_o);
    check_reg("rs1_addr", regs[3*RB-1:2*RB], rs1_addr_o);
    check_reg("rs2_addr", regs[2*RB-1:RB], rs2_addr_o);
    check_reg("rd_addr", regs[RB-1:0], rd_addr_o);
    check_alu("alu_operation", ref_alu_op(w), alu_operation_o);
    check_code("word_size", sized ? w.r.funct3 : 3'b0, word_size_o);
    check_word("immediate", ref_imm(w, pc), immediate_o);
    check_flag("immediate_valid", ref_imm_valid(w), immediate_valid_o);
    check_code("stage4_path", ref_stage4(w), stage4_path_o);
    check_flag("branch", op == rv32im_pkg::OP_B, branch_o);
    check_code("branch_condition", (op == rv32im_pkg::OP_B) ? w.b.funct3 : 3'b0,
               branch_condition_o);
    check_flag("jal_jump", jal, jal_jump_o);
    check_flag("jalr", jalr, jalr_o);
    check_flag("link", jal || jalr, link_o);
    check_word("link_data", pc + 32'd4, link_data_o);
    check_flag("memory_write", op == rv32im_pkg::OP_S, memory_write_o);
    check_flag("mret", op == rv32im_pkg::OP_SYS, mret_o);
    check_flag("push_ras", push, push_ras_o);
    check_flag("pop_ras", pop, pop_ras_o);
    exp_next_pc = ref_next_pc(w, pc, top);
    if (jal)
      check_word("jal_target", exp_next_pc, pc_jal_data_o);
    pc_pending = 1'b1;
    if (push && pop)
      ras_q[ras_q.size() - 1] = pc + 32'd4;  // Replace top
    else if (push)
      ras_q.push_back(pc + 32'd4);
    else if (pop && ras_q.size() != 0)
      void'(ras_q.pop_back());
  endtask

  always @(posedge clk_i)
  begin
    if (pc_pending)
    begin
      check_word("next pc", exp_next_pc, pc_o);
      pc_pending = 1'b0;
      done_cnt <= done_cnt + 1;
    end
    if (rst_n_i && issue_o)
    begin
      if (word_q.size() == 0)
      begin
        $display("%s: an instruction issued that was never expected", test_name);
        err_cnt++;
      end
      else
        compare_issue(word_q.pop_front(), pc_q.pop_front());
    end
  end

  // One strobe at the current PC and a wrong-path strobe behind each jump
  task automatic fetch_one();
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] w;
    int              start;
    int              n;
    start = done_cnt;
    @(posedge clk_i);
    pc = pc_o;
    w  = read_mem(pc);
    word_q.push_back(w);
    pc_q.push_back(pc);
    instr_i       <= w;
    instr_valid_i <= 1'b1;
    @(posedge clk_i);
    if (w[6:2] == rv32im_pkg::OP_JAL || w[6:2] == rv32im_pkg::OP_JALR)
      instr_i <= read_mem(pc + 32'd4);
    else
      instr_valid_i <= 1'b0;
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    n = 0;
    while (done_cnt == start && n < 20)
    begin
      @(posedge clk_i);
      n++;
    end
    if (done_cnt == start)
    begin
      $display("%s: word at pc %h was not issued in time", test_name, pc);
      err_cnt++;
      word_q.delete();
      pc_q.delete();
    end
  endtask

  task automatic close_test(input int errs0);
    $display("%-16s %0d errors", test_name, err_cnt - errs0);
    if (err_cnt == errs0)
      pass_cnt++;
    else
      fail_cnt++;
  endtask

  task automatic run_test(input string name, input int count);
    int errs0;
    errs0     = err_cnt;
    test_name = name;
    for (int k = 0; k < count; k++)
      fetch_one();
    close_test(errs0);
  endtask

  initial
  begin
    int              errs0;
    logic [XLEN-1:0] trap_pc;
    instr_i       = '0;
    instr_valid_i = 1'b0;
    irq_i         = 1'b0;
    rst_n_i       = 1'b0;
    seed          = 31375;
    load_program();
    repeat (2) @(posedge clk_i);
    errs0     = err_cnt;
    test_name = "reset_state";
    check_word("pc", '0, pc_o);
    check_word("uepc", '0, uepc_o);
    check_flag("issue", 1'b0, issue_o);
    check_flag("jal_jump", 1'b0, jal_jump_o);
    check_flag("jalr", 1'b0, jalr_o);
    check_flag("branch", 1'b0, branch_o);
    check_flag("link", 1'b0, link_o);
    check_flag("memory_write", 1'b0, memory_write_o);
    check_flag("mret", 1'b0, mret_o);
    check_flag("immediate_valid", 1'b0, immediate_valid_o);
    check_flag("push_ras", 1'b0, push_ras_o);
    check_flag("pop_ras", 1'b0, pop_ras_o);
    close_test(errs0);
    rst_n_i <= 1'b1;

    run_test("alu_mem_words", 10);
    run_test("upper_branch", 4);
    run_test("jal_redirect", 2);
    run_test("call_return", 10);

    errs0     = err_cnt;
    test_name = "irq_capture";
    @(posedge clk_i);
    check_word("uepc_before_irq", '0, uepc_o);  // No capture without irq
    irq_i <= 1'b1;
    @(posedge clk_i);
    trap_pc = exp_next_pc;  // Front end idles at the last expected PC
    irq_i <= 1'b0;
    @(posedge clk_i);
    check_word("uepc", trap_pc, uepc_o);
    close_test(errs0);

    $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    repeat (5000) @(posedge clk_i);
    $display("simulation timed out in %s", test_name);
    $display("Test failed");
    $finish;
  end

endmodule

/* all.f */
+incdir+include
source/rv32im_pkg.sv
source/rv32im_imm_gen.sv
source/rv32im_decode.sv
source/rv32im_ras.sv
source/rv32im_fetch.sv
source/rv32im_front.sv
testbench/tb_rv32im_front.sv

/* Bender.yml */
package:
  name: rv32im_front

sources:
  - source/rv32im_pkg.sv
  - source/rv32im_imm_gen.sv
  - source/rv32im_decode.sv
  - source/rv32im_ras.sv
  - source/rv32im_fetch.sv
  - source/rv32im_front.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_rv32im_front.sv
